// ==== tb/vicii_golden.txt ====
// columns: op[31:28] arg[27:16] data[15:0]
// 1 chip {sw,ext} cycles | 2 write addr data | 3 read addr expected | 4 irq fall lines
// 5 bad line raster expected | 6 refresh start lines | f end
20110013  // den on, yscroll 3
30110013
2018005A  // vm 5, cb 5
3018005B  // bit 0 reads as 1
302000FF  // unused register
301A00FE  // enable clear
3019007F  // compare 0 matched at reset
20190001  // ack the flag
3019007E
20120040  // compare line 0x40, enable still clear
40000050  // no irq within 80 lines
3019007F  // flag set but not enabled
20190001
3019007E
20120090
201A0001
301A00FF
4001012C  // irq at line 0x90, 300 line limit
301900FF
20190001
3019007E
201A0000
503B0001  // second character row, vc base 40
50450000  // low bits 5, no dma
50730001  // ninth row, vc base 320
61050004  // across the frame wrap at 263
1000003F  // ext 00 with the switch low runs 63 cycles
1011003F
10120040
10130041
10100041
F0000000

// ==== vicii_board_top.f ====
hdl/vic_pkg.sv
hdl/bus_pkg.sv
hdl/raster_counter.sv
hdl/vic_registers.sv
hdl/fetch_sequencer.sv
hdl/refresh_counter.sv
hdl/bus_arbiter.sv
hdl/vicii_board_top.sv
tb/tb_vicii_board_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
   echo "verilator not found"
   exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_vicii_board_top \
      -f vicii_board_top.f; then
   echo "build failed"
   exit 1
fi

if ! out="$(./obj_dir/Vtb_vicii_board_top 2>&1)"; then
   echo "$out"
   echo "simulation exited with an error"
   exit 1
fi
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
   exit 0
fi
exit 1

// ==== tb/tb_vicii_board_top.sv ====
`default_nettype none

module tb_vicii_board_top;

   logic        sys_clock;
   logic        rst_n;
   logic [1:0]  chip_ext;
   logic        standard_sw;
   logic        ce;
   logic        rw;
   logic [5:0]  adi;
   logic [7:0]  dbi;
   logic        clk_phi;
   logic [7:0]  dbo;
   logic        vic_write_db;
   logic [13:0] ado;
   logic        vic_write_ab;
   logic        ras;
   logic        cas;
   logic        irq;
   logic        aec;
   logic        ba;

   logic [31:0] golden [64];  // op, arg, data per word
   logic [31:0] rng = 32'h274b_10c1;
   int          errors = 0;
   int          checks = 0;

   // reference timing model, follows the slot rules from reset
   logic        m_phi;
   int          m_cycle;
   int          m_raster;
   logic [1:0]  m_model;
   logic [7:0]  m_ref;     // refresh counter expected in the current slot

   // register state as written by the testbench
   logic [3:0]  vm_m = 4'd0;
   logic [2:0]  cb_m = 3'd0;
   logic [8:0]  cmp_m = 9'd0;
   int          ysc_m = 0;

   vicii_board_top i_dut (
      .sys_clock(sys_clock), .rst_n(rst_n), .chip_ext(chip_ext),
      .standard_sw(standard_sw), .ce(ce), .rw(rw), .adi(adi), .dbi(dbi),
      .clk_phi(clk_phi), .dbo(dbo), .vic_write_db(vic_write_db), .ado(ado),
      .vic_write_ab(vic_write_ab), .ras(ras), .cas(cas), .irq(irq), .aec(aec), .ba(ba)
   );

   initial begin
      sys_clock = 1'b0;
      forever #20 sys_clock = ~sys_clock;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int line_cycles(input logic [1:0] model);
      case (model)
         2'b01:   return 63;
         2'b10:   return 64;
         default: return 65;  // 00 and 11
      endcase
   endfunction

   function automatic int frame_lines(input logic [1:0] model);
      case (model)
         2'b00:   return 263;
         2'b10:   return 262;
         default: return 312;
      endcase
   endfunction

   // switch low flips the pal/ntsc bit
   function automatic logic [1:0] decode_chip(input logic [1:0] ext, input logic sw);
      return {ext[1], sw ? ext[0] : !ext[0]};
   endfunction

   always @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         m_phi    <= 1'b0;
         m_cycle  <= 0;
         m_raster <= 0;
         m_model  <= decode_chip(chip_ext, standard_sw);
         m_ref    <= 8'hFF;
      end else begin
         m_phi <= !m_phi;
         if (!m_phi && m_cycle >= 11 && m_cycle <= 15)
            m_ref <= m_ref - 8'd1;  // one step per refresh slot
         if (m_phi) begin
            if (m_cycle >= line_cycles(m_model) - 1) begin
               m_cycle <= 0;
               m_model <= decode_chip(chip_ext, standard_sw);  // new model at line start
               if (m_raster >= frame_lines(m_model) - 1) begin
                  m_raster <= 0;
                  m_ref    <= 8'hFF;
               end else begin
                  m_raster <= m_raster + 1;
               end
            end else begin
               m_cycle <= m_cycle + 1;
            end
         end
      end
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic require(input bit ok, input string what);
      checks++;
      assert (ok) else begin
         errors++;
         $display("failure at %0t: %s", $time, what);
      end
   endtask

   always @(negedge sys_clock) begin
      if (rst_n)
         compare("clk_phi", 32'(clk_phi), 32'(m_phi));  // model stays in step
   end

   // returns at the phi-low slot of cycle cyc, any line when line is negative
   task automatic wait_slot(input int line, input int cyc, output bit ok);
      int n;
      n = 0;
      @(negedge sys_clock);
      while (!(!m_phi && m_cycle == cyc && (line < 0 || m_raster == line)) && n < 50000) begin
         @(negedge sys_clock);
         n++;
      end
      ok = (n < 50000);
   endtask

   task automatic cpu_access(input bit write, input logic [5:0] addr, input logic [7:0] wdata,
                             output logic [7:0] rdata);
      int n;
      n = 0;
      @(negedge sys_clock);
      while ((m_phi || !ba) && n < 2000) begin  // ba high, so aec stays high next slot
         @(negedge sys_clock);
         n++;
      end
      require(n < 2000, "timeout waiting for a free cpu slot");
      @(posedge sys_clock);
      ce  <= 1'b0;
      rw  <= !write;
      adi <= addr;
      dbi <= wdata;
      @(negedge sys_clock);  // phi-high slot of the access
      compare("aec", 32'(aec), 32'd1);
      @(posedge sys_clock);
      ce <= 1'b1;
      rw <= 1'b1;
      @(negedge sys_clock);  // slot after the access
      compare("vic_write_db", 32'(vic_write_db), 32'(!write));
      rdata = dbo;
      if (write) begin
         case (addr)
            6'h11: begin
               cmp_m[8] = wdata[7];
               ysc_m    = int'(wdata[2:0]);
            end
            6'h12: cmp_m[7:0] = wdata;
            6'h18: begin
               vm_m = wdata[7:4];
               cb_m = wdata[3:1];
            end
            default: ;
         endcase
      end
   endtask

   task automatic wait_irq(input bit exp_fall, input int max_lines);
      int  lines;
      int  n;
      bit  fell;
      lines = 0;
      n     = 0;
      fell  = 0;
      while (!fell && lines < max_lines && n < 200000) begin
         @(negedge sys_clock);
         n++;
         if (!irq)
            fell = 1;
         else if (!m_phi && m_cycle == 0)
            lines++;
      end
      if (exp_fall) begin
         require(fell, "irq did not fall within the line limit");
         if (fell)
            compare("raster at irq", m_raster, 32'(cmp_m));
      end else begin
         require(!fell, "irq fell while the raster interrupt was disabled");
      end
   endtask

   // watches line and the line after it, matrix fetches then character fetches
   task automatic check_bad_line(input int line, input bit exp_bad);
      logic [7:0]           codes [40];
      bus_pkg::video_addr_t exp_a;
      int                   vcb;
      int                   col;
      int                   n;
      bit                   ok;
      wait_slot(line, 0, ok);
      require(ok, $sformatf("timeout waiting for raster line %0d", line));
      vcb = (line - 'h30 - ysc_m) / 8 * 40;  // rows since the first bad line
      n   = 0;
      while ((m_raster == line || m_raster == line + 1) && n < 400) begin
         col = m_cycle - 15;
         if (m_raster == line) begin
            compare("ba", 32'(ba), 32'(!(exp_bad && m_cycle >= 12 && m_cycle <= 54)));
            if (exp_bad && m_phi && col >= 0 && col < 40) begin
               exp_a             = '0;
               exp_a.matrix.vm   = vm_m;
               exp_a.matrix.vc   = 10'(vcb + col);
               compare("aec", 32'(aec), 32'd0);
               compare("ado", 32'(ado), 32'(exp_a));
               compare("cas", 32'(cas), 32'd0);
            end
         end else if (exp_bad && !m_phi && col >= 1 && col < 40) begin
            exp_a            = '0;  // cycle 15 phi-low belongs to refresh
            exp_a.chars.cb   = cb_m;
            exp_a.chars.code = codes[col];
            exp_a.chars.rc   = 3'd1;
            compare("ado", 32'(ado), 32'(exp_a));
            compare("vic_write_ab", 32'(vic_write_ab), 32'd1);
            compare("cas", 32'(cas), 32'd0);
         end
         if (exp_bad && m_raster == line && !m_phi && col >= 0 && col < 40) begin
            rng        = xorshift(rng);  // screen code for the coming matrix slot
            codes[col] = rng[7:0];
            @(posedge sys_clock);
            dbi <= rng[7:0];
         end
         @(negedge sys_clock);
         n++;
      end
      require(n < 400, $sformatf("timeout while watching raster line %0d", line));
   endtask

   task automatic check_refresh(input int start, input int lines);
      int  seen;
      int  n;
      int  line_now;
      int  left;
      bit  ok;
      wait_slot(start, 0, ok);
      require(ok, $sformatf("timeout waiting for raster line %0d", start));
      seen     = 0;
      n        = 0;
      left     = lines;
      line_now = m_raster;
      while (left > 0 && n < 200000) begin
         if (!ras && cas && vic_write_ab)
            seen++;  // ras only access seen on the pins
         if (!m_phi && m_cycle >= 11 && m_cycle <= 15) begin
            compare("ado", 32'(ado), 32'(14'h3F00 + 14'(m_ref)));
            compare("ras", 32'(ras), 32'd0);
            compare("cas", 32'(cas), 32'd1);  // ras only cycle
            if (m_raster == 0 && m_cycle == 11)
               compare("ado", 32'(ado), 32'h3FFF);  // counter reloaded
         end
         @(negedge sys_clock);
         n++;
         if (m_raster != line_now) begin
            compare("refresh count", seen, 5);
            seen     = 0;
            line_now = m_raster;
            left--;
         end
      end
      require(left == 0, "timeout while watching refresh lines");
   endtask

   // distance between refresh groups gives the cycles per line
   task automatic check_chip(input logic [1:0] ext, input logic sw, input int exp_cycles);
      int n;
      int last;
      int first;
      int spacing;
      bit ok;
      wait_slot(-1, 1, ok);  // change the model early in a line
      require(ok, "timeout waiting for cycle 1 of a line");
      @(posedge sys_clock);
      chip_ext    <= ext;
      standard_sw <= sw;
      wait_slot(-1, 0, ok);
      require(ok, "timeout waiting for a line start");
      n       = 0;
      last    = -10;
      first   = -1;
      spacing = 0;
      while (spacing == 0 && n < 2000) begin
         @(negedge sys_clock);
         n++;
         if (!ras && cas && vic_write_ab) begin
            if (n - last > 2) begin
               if (first < 0)
                  first = n;
               else
                  spacing = (n - first) / 2;
            end
            last = n;
         end
      end
      require(spacing != 0, "no two refresh groups seen");
      compare("refresh spacing", spacing, exp_cycles);
   endtask

   initial begin
      logic [31:0] cmd;
      logic [3:0]  op;
      logic [11:0] arg;
      logic [15:0] dat;
      logic [7:0]  rd;
      int          i;
      bit          done;
      rst_n       = 1'b0;
      chip_ext    = 2'b00;
      standard_sw = 1'b1;
      ce          = 1'b1;
      rw          = 1'b1;
      adi         = 6'd0;
      dbi         = 8'd0;
      done        = 0;
      i           = 0;
      $readmemh("tb/vicii_golden.txt", golden);
      repeat (10) @(posedge sys_clock);
      rst_n <= 1'b1;
      @(negedge sys_clock);
      compare("irq", 32'(irq), 32'd1);
      compare("ba", 32'(ba), 32'd1);
      compare("aec", 32'(aec), 32'd1);
      compare("vic_write_db", 32'(vic_write_db), 32'd0);
      while (!done && i < 64) begin
         cmd = golden[i];
         op  = cmd[31:28];
         arg = cmd[27:16];
         dat = cmd[15:0];
         case (op)
            4'h1: check_chip(arg[1:0], arg[4], int'(dat));
            4'h2: cpu_access(1'b1, arg[5:0], dat[7:0], rd);
            4'h3: begin
               cpu_access(1'b0, arg[5:0], 8'h00, rd);
               compare("dbo", 32'(rd), 32'(dat[7:0]));
            end
            4'h4: wait_irq(arg[0], int'(dat));
            4'h5: check_bad_line(int'(arg), dat[0]);
            4'h6: check_refresh(int'(arg), int'(dat));
            4'hF: done = 1;
            default: require(0, $sformatf("unknown command %h in the golden file", cmd));
         endcase
         i++;
      end
      require(done, "golden file ended without an end command");
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule : tb_vicii_board_top

`default_nettype wire

// ==== hdl/vicii_board_top.sv ====
`default_nettype none

module vicii_board_top (
   input  wire         sys_clock,
   input  wire         rst_n,
   input  wire  [1:0]  chip_ext,
   input  wire         standard_sw,
   input  wire         ce,
   input  wire         rw,
   input  wire  [5:0]  adi,
   input  wire  [7:0]  dbi,
   output wire         clk_phi,
   output wire  [7:0]  dbo,
   output wire         vic_write_db,  // enable for dbo
   output wire  [13:0] ado,
   output wire         vic_write_ab,  // enable for ado
   output wire         ras,
   output wire         cas,
   output wire         irq,
   output wire         aec,
   output wire         ba
);

   wire [6:0]  cycle;
   wire [8:0]  raster;
   wire        bad_line;
   wire        line_start;
   wire        den;
   wire [2:0]  yscroll;
   wire [3:0]  vm;
   wire [2:0]  cb;
   wire        fetch_req;
   wire [13:0] fetch_addr;
   wire        refresh_req;
   wire [13:0] refresh_addr;

   raster_counter i_raster_counter (
      .sys_clock(sys_clock), .rst_n(rst_n), .chip_ext(chip_ext),
      .standard_sw(standard_sw), .den(den), .yscroll(yscroll),
      .phi(clk_phi), .cycle(cycle), .raster(raster), .bad_line(bad_line),
      .ba(ba), .aec(aec), .line_start(line_start)
   );

   vic_registers i_vic_registers (
      .sys_clock(sys_clock), .rst_n(rst_n), .phi(clk_phi), .aec(aec),
      .ce(ce), .rw(rw), .adi(adi), .dbi(dbi), .raster(raster),
      .line_start(line_start), .dbo(dbo), .vic_write_db(vic_write_db),
      .den(den), .yscroll(yscroll), .vm(vm), .cb(cb), .irq(irq)
   );

   fetch_sequencer i_fetch_sequencer (
      .sys_clock(sys_clock), .rst_n(rst_n), .phi(clk_phi), .cycle(cycle),
      .raster(raster), .bad_line(bad_line), .line_start(line_start),
      .vm(vm), .cb(cb), .dbi(dbi), .fetch_req(fetch_req), .fetch_addr(fetch_addr)
   );

   refresh_counter i_refresh_counter (
      .sys_clock(sys_clock), .rst_n(rst_n), .phi(clk_phi), .cycle(cycle),
      .raster(raster), .refresh_req(refresh_req), .refresh_addr(refresh_addr)
   );

   bus_arbiter i_bus_arbiter (
      .sys_clock(sys_clock), .rst_n(rst_n), .phi(clk_phi), .aec(aec),
      .refresh_req(refresh_req), .refresh_addr(refresh_addr),
      .fetch_req(fetch_req), .fetch_addr(fetch_addr),
      .ado(ado), .vic_write_ab(vic_write_ab), .ras(ras), .cas(cas)
   );

endmodule : vicii_board_top

`default_nettype wire

// ==== hdl/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter (
   input  wire         sys_clock,
   input  wire         rst_n,
   input  wire         phi,
   input  wire         aec,
   input  wire         refresh_req,
   input  wire  [13:0] refresh_addr,
   input  wire         fetch_req,
   input  wire  [13:0] fetch_addr,
   output logic [13:0] ado,
   output logic        vic_write_ab,
   output logic        ras,
   output logic        cas
);

   bus_pkg::slot_owner_t owner;

   // refresh beats fetch in phi-low, aec decides phi-high
   always_comb begin
      if (!phi)
         owner = refresh_req ? bus_pkg::slot_refresh
               : fetch_req   ? bus_pkg::slot_fetch
               :               bus_pkg::slot_idle;
      else
         owner = aec ? bus_pkg::slot_cpu : bus_pkg::slot_fetch;
   end

   always_comb begin
      ado          = 14'd0;
      vic_write_ab = 1'b0;
      ras          = 1'b1;
      cas          = 1'b1;
      case (owner)
         bus_pkg::slot_refresh: begin
            ado          = refresh_addr;
            vic_write_ab = 1'b1;
            ras          = 1'b0;  // ras only refresh, cas stays high
         end
         bus_pkg::slot_fetch: begin
            ado          = fetch_addr;
            vic_write_ab = 1'b1;
            ras          = 1'b0;
            cas          = 1'b0;
         end
         bus_pkg::slot_cpu: begin
            ras = 1'b0;  // cpu drives the address, strobes still from here
            cas = 1'b0;
         end
         default: ;  // idle, bus released
      endcase
   end

   // refresh and fetch never share a slot, refresh never loses
   a_grant_excl : assert property (@(posedge sys_clock) disable iff (!rst_n)
      refresh_req |-> owner == bus_pkg::slot_refresh);

   // a matrix request in phi-high always finds aec low
   a_matrix_granted : assert property (@(posedge sys_clock) disable iff (!rst_n)
      (phi && fetch_req) |-> owner == bus_pkg::slot_fetch);

endmodule : bus_arbiter

`default_nettype wire

// ==== hdl/refresh_counter.sv ====
`default_nettype none

module refresh_counter (
   input  wire         sys_clock,
   input  wire         rst_n,
   input  wire         phi,
   input  wire  [6:0]  cycle,
   input  wire  [8:0]  raster,
   output logic        refresh_req,
   output logic [13:0] refresh_addr
);

   logic [7:0] ref_cnt;  // counts down, one per access

   // five phi-low slots starting at cycle 11
   assign refresh_req = !phi && (cycle >= vic_pkg::refresh_first_cycle)
                        && (cycle < vic_pkg::refresh_first_cycle + vic_pkg::refresh_count);

   assign refresh_addr = bus_pkg::refresh_base + 14'(ref_cnt);

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         ref_cnt <= 8'hFF;
      end else if (!phi && cycle == 7'd0 && raster == 9'd0) begin
         ref_cnt <= 8'hFF;  // reload each frame
      end else if (refresh_req) begin
         ref_cnt <= ref_cnt - 8'd1;
      end
   end

endmodule : refresh_counter

`default_nettype wire

// ==== hdl/fetch_sequencer.sv ====
`default_nettype none

module fetch_sequencer (
   input  wire         sys_clock,
   input  wire         rst_n,
   input  wire         phi,
   input  wire  [6:0]  cycle,
   input  wire  [8:0]  raster,
   input  wire         bad_line,
   input  wire         line_start,
   input  wire  [3:0]  vm,
   input  wire  [2:0]  cb,
   input  wire  [7:0]  dbi,
   output logic        fetch_req,
   output logic [13:0] fetch_addr
);

   logic [9:0]          vc_base;        // video counter at start of the row
   logic [2:0]          rc;             // row within the character
   logic                disp;           // display state, char fetches enabled
   logic [7:0]          line_buf [40];  // screen codes of the current row
   logic                in_fetch;
   logic [5:0]          col;
   logic                matrix_req;
   logic                char_req;
   bus_pkg::video_addr_t addr_u;

   assign in_fetch = (cycle >= vic_pkg::fetch_start_cycle) && (cycle <= vic_pkg::fetch_end_cycle);
   assign col      = 6'(cycle - vic_pkg::fetch_start_cycle);  // 0..39 inside the window

   assign matrix_req = phi && bad_line && in_fetch;  // stolen phi-high slots
   assign char_req   = !phi && in_fetch && disp;
   assign fetch_req  = matrix_req || char_req;

   always_comb begin
      addr_u = '0;
      if (phi) begin
         addr_u.matrix.vm = vm;
         addr_u.matrix.vc = vc_base + 10'(col);
      end else begin
         addr_u.chars.cb   = cb;
         addr_u.chars.code = line_buf[col];
         addr_u.chars.rc   = rc;
      end
   end

   assign fetch_addr = addr_u;

   // row bookkeeping once per line
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         vc_base <= 10'd0;
         rc      <= 3'd0;
         disp    <= 1'b0;
      end else if (line_start) begin
         if (raster == 9'd0) begin
            vc_base <= 10'd0;  // top of frame
            rc      <= 3'd0;
            disp    <= 1'b0;
         end else begin
            if (disp && rc == 3'd7)
               vc_base <= vc_base + 10'd40;  // previous row finished
            rc   <= bad_line ? 3'd0 : rc + 3'd1;
            disp <= bad_line || (disp && rc != 3'd7);  // idle after the last row line
         end
      end
   end

   // screen codes latched as the matrix slot closes
   always_ff @(posedge sys_clock) begin
      if (matrix_req)
         line_buf[col] <= dbi;
   end

endmodule : fetch_sequencer

`default_nettype wire

// ==== hdl/vic_registers.sv ====
`default_nettype none

module vic_registers (
   input  wire        sys_clock,
   input  wire        rst_n,
   input  wire        phi,
   input  wire        aec,
   input  wire        ce,          // active low chip enable
   input  wire        rw,          // high read, low write
   input  wire  [5:0] adi,
   input  wire  [7:0] dbi,
   input  wire  [8:0] raster,
   input  wire        line_start,
   output logic [7:0] dbo,
   output logic       vic_write_db,
   output logic       den,
   output logic [2:0] yscroll,
   output logic [3:0] vm,
   output logic [2:0] cb,
   output logic       irq
);

   logic       access;    // cpu access in this phi-high slot
   logic [6:0] ctrl1;     // 0x11 without the raster bit
   logic       cmp8;      // compare bit 8
   logic [7:0] cmp_lo;    // compare bits 7:0
   logic       irq_flag;  // raster flag
   logic       irq_en;
   logic [7:0] rd_data;

   assign access = phi && !ce && aec;

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         ctrl1        <= 7'd0;
         cmp8         <= 1'b0;
         cmp_lo       <= 8'd0;
         vm           <= 4'd0;
         cb           <= 3'd0;
         irq_flag     <= 1'b0;
         irq_en       <= 1'b0;
         vic_write_db <= 1'b0;
      end else begin
         vic_write_db <= access && rw;  // one slot, the following phi-low
         // compare match only checked at line start
         if (line_start && raster == {cmp8, cmp_lo})
            irq_flag <= 1'b1;
         if (access && !rw) begin
            case (adi)
               vic_pkg::reg_ctrl1: begin
                  ctrl1 <= dbi[6:0];
                  cmp8  <= dbi[7];
               end
               vic_pkg::reg_raster: cmp_lo <= dbi;
               vic_pkg::reg_mem_ptr: begin
                  vm <= dbi[7:4];
                  cb <= dbi[3:1];
               end
               vic_pkg::reg_irq_status: if (dbi[0]) irq_flag <= 1'b0;  // write 1 to ack
               vic_pkg::reg_irq_enable: irq_en <= dbi[0];
               default: ;
            endcase
         end
      end
   end

   assign den     = ctrl1[4];
   assign yscroll = ctrl1[2:0];
   assign irq     = !(irq_flag && irq_en);  // open drain style, low active

   always_comb begin
      case (adi)
         vic_pkg::reg_ctrl1:      rd_data = {raster[8], ctrl1};
         vic_pkg::reg_raster:     rd_data = raster[7:0];  // live counter, not compare
         vic_pkg::reg_mem_ptr:    rd_data = {vm, cb, 1'b1};
         vic_pkg::reg_irq_status: rd_data = {irq_flag && irq_en, 6'h3F, irq_flag};
         vic_pkg::reg_irq_enable: rd_data = {7'h7F, irq_en};
         default:                 rd_data = 8'hFF;
      endcase
   end

   // read data captured at the access edge
   always_ff @(posedge sys_clock) begin
      if (access && rw)
         dbo <= rd_data;
   end

   // read data never collides with a cpu phi-high slot
   a_db_phase : assert property (@(posedge sys_clock) disable iff (!rst_n)
      vic_write_db |-> !phi);

endmodule : vic_registers

`default_nettype wire

// ==== hdl/raster_counter.sv ====
`default_nettype none

module raster_counter (
   input  wire        sys_clock,
   input  wire        rst_n,
   input  wire  [1:0] chip_ext,     // chip code from the mcu
   input  wire        standard_sw,  // board switch, low flips pal/ntsc
   input  wire        den,
   input  wire  [2:0] yscroll,
   output logic       phi,
   output logic [6:0] cycle,
   output logic [8:0] raster,
   output logic       bad_line,
   output logic       ba,
   output logic       aec,
   output logic       line_start
);

   logic [1:0] chip;       // decoded model
   logic [1:0] chip_q;     // model in use for the current line
   logic       last_cycle;
   logic       last_line;
   logic       den_seen;   // den was set on the first dma line
   logic       in_dma;
   logic       den_ok;

   assign chip = {chip_ext[1], standard_sw ? chip_ext[0] : ~chip_ext[0]};

   // >= so a model change mid-line still wraps cleanly
   assign last_cycle = cycle >= 7'(vic_pkg::chip_cycles[chip_q] - 7'd1);
   assign last_line  = raster >= 9'(vic_pkg::chip_lines[chip_q] - 9'd1);
   assign line_start = !phi && (cycle == 7'd0);  // first slot of a line

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         phi    <= 1'b0;
         cycle  <= 7'd0;
         raster <= 9'd0;
         chip_q <= 2'b00;
      end else begin
         phi <= ~phi;
         if (phi) begin  // end of the cycle
            if (last_cycle) begin
               cycle  <= 7'd0;
               chip_q <= chip;  // new model takes effect at a line boundary
               raster <= last_line ? 9'd0 : raster + 9'd1;
            end else begin
               cycle <= cycle + 7'd1;
            end
         end
      end
   end

   // den is only looked at during line 0x30
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         den_seen <= 1'b0;
      end else if (line_start && raster == 9'd0) begin
         den_seen <= 1'b0;  // new frame
      end else if (raster == vic_pkg::first_dma_line && den) begin
         den_seen <= 1'b1;
      end
   end

   assign in_dma = (raster >= vic_pkg::first_dma_line) && (raster <= vic_pkg::last_dma_line);
   assign den_ok = den_seen || (raster == vic_pkg::first_dma_line && den);
   assign bad_line = in_dma && den_ok && (raster[2:0] == yscroll);

   // ba warns the cpu three cycles before aec takes the phi-high slots
   assign ba  = !(bad_line && cycle >= vic_pkg::ba_start_cycle
                  && cycle <= vic_pkg::fetch_end_cycle);
   assign aec = !(bad_line && phi && cycle >= vic_pkg::fetch_start_cycle
                  && cycle <= vic_pkg::fetch_end_cycle);

   // cycle counter never runs past the model latched for this line
   a_cycle_range : assert property (@(posedge sys_clock) disable iff (!rst_n)
      cycle < vic_pkg::chip_cycles[chip_q]);

endmodule : raster_counter

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

   // who owns a half-cycle slot on the memory bus
   typedef enum logic [1:0] {
      slot_idle    = 2'b00,
      slot_refresh = 2'b01,
      slot_fetch   = 2'b10,
      slot_cpu     = 2'b11
   } slot_owner_t;

   localparam logic [13:0] refresh_base = 14'h3F00;  // refresh row counter sits on top

   // matrix fetch address, video matrix base + video counter
   typedef struct packed {
      logic [3:0] vm;
      logic [9:0] vc;
   } matrix_addr_t;

   // character fetch address, char base + screen code + row
   typedef struct packed {
      logic [2:0] cb;
      logic [7:0] code;
      logic [2:0] rc;
   } char_addr_t;

   // one 14 bit vic address, two decodings
   typedef union packed {
      matrix_addr_t matrix;
      char_addr_t   chars;
   } video_addr_t;

endpackage : bus_pkg

`default_nettype wire

// ==== hdl/vic_pkg.sv ====
`default_nettype none

package vic_pkg;

   // cycles per line, indexed by the 2-bit chip code
   localparam logic [6:0] chip_cycles [4] = '{
      7'd65,  // 00 ntsc 6567r8
      7'd63,  // 01 pal 6569
      7'd64,  // 10 ntsc 6567r56a
      7'd65   // 11 pal-n 6572
   };

   // lines per frame, same indexing
   localparam logic [8:0] chip_lines [4] = '{
      9'd263,
      9'd312,
      9'd262,
      9'd312
   };

   // cpu visible register addresses
   localparam logic [5:0] reg_ctrl1      = 6'h11;  // raster8, den, yscroll
   localparam logic [5:0] reg_raster     = 6'h12;
   localparam logic [5:0] reg_mem_ptr    = 6'h18;  // vm and cb
   localparam logic [5:0] reg_irq_status = 6'h19;
   localparam logic [5:0] reg_irq_enable = 6'h1A;

   // bad lines only inside this range
   localparam logic [8:0] first_dma_line = 9'h030;
   localparam logic [8:0] last_dma_line  = 9'h0F7;

   // bad line window in cycles
   localparam logic [6:0] ba_start_cycle    = 7'd12;
   localparam logic [6:0] fetch_start_cycle = 7'd15;
   localparam logic [6:0] fetch_end_cycle   = 7'd54;

   // dram refresh placement
   localparam logic [6:0] refresh_first_cycle = 7'd11;
   localparam logic [6:0] refresh_count       = 7'd5;

endpackage : vic_pkg

`default_nettype wire
